// ==== cpu_pkg.sv ====
/*
 * cpu package
 * pipeline widths and the load/store operation encoding
 */
package cpu_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // field positions inside lsu_op_e
  localparam int unsigned OP_STORE_BIT    = 3;
  localparam int unsigned OP_UNSIGNED_BIT = 2;

  // access size field, op bits 1:0
  localparam logic [1:0] OP_SZ_B = 2'b00;
  localparam logic [1:0] OP_SZ_H = 2'b01;
  localparam logic [1:0] OP_SZ_W = 2'b10;

  // top bit is store, bit 2 is unsigned, low bits are the size
  typedef enum logic [3:0] {
    LB  = 4'b0000,
    LH  = 4'b0001,
    LW  = 4'b0010,
    LBU = 4'b0100,
    LHU = 4'b0101,
    SB  = 4'b1000,
    SH  = 4'b1001,
    SW  = 4'b1010
  } lsu_op_e;

endpackage

// ==== axi_pkg.sv ====
/*
 * axi package
 * bus widths, response and size codes, watchdog length and the beat views
 */
package axi_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 64;
  localparam int unsigned STRB_W = DATA_W / 8;

  // cycles allowed between address acceptance and the response
  localparam int unsigned TIMEOUT_CYCLES = 16;
  localparam int unsigned TIMER_W        = $clog2(TIMEOUT_CYCLES + 1);
  localparam logic [TIMER_W-1:0] TIMEOUT_MAX = TIMER_W'(TIMEOUT_CYCLES);

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  typedef enum logic [2:0] {
    SIZE_1B = 3'b000,
    SIZE_2B = 3'b001,
    SIZE_4B = 3'b010
  } size_e;

  // one bus word seen by byte, half or word lane
  typedef union packed {
    logic [STRB_W-1:0][7:0]        bytes;
    logic [DATA_W/16-1:0][15:0]    halves;
    logic [DATA_W/32-1:0][31:0]    words;
  } beat_u;

endpackage

// ==== lsu_if.sv ====
/*
 * lsu status interface
 * access completion, fault, busy and load value toward writeback
 */
`timescale 1ns/1ps

interface lsu_if;

  logic                     done;
  logic                     fault;
  logic                     busy;
  logic [cpu_pkg::XLEN-1:0] load_value;

  modport fsm   (output done, fault, busy);
  modport align (output load_value);
  modport wb    (input done, fault, busy, load_value);

endinterface

// ==== lsu_fsm.sv ====
/*
 * lsu control FSM
 * sequences single-beat AXI reads and writes, drives stall and fault
 */
`timescale 1ns/1ps

module lsu_fsm (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              lsu_m,
  input  cpu_pkg::lsu_op_e  lsu_op_m,
  input  logic [2:0]        addr_lo,
  output logic              arvalid,
  input  logic              arready,
  input  logic              rvalid,
  input  axi_pkg::resp_e    rresp,
  output logic              rready,
  output logic              awvalid,
  input  logic              awready,
  output logic              wvalid,
  input  logic              wready,
  input  logic              bvalid,
  input  axi_pkg::resp_e    bresp,
  output logic              bready,
  output logic              start,
  output logic              stop,
  input  logic              expired,
  output logic              mem_stall,
  lsu_if.fsm                lsu
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MISAL,
    ST_RD_ADDR,
    ST_RD_DATA,
    ST_WR,
    ST_WR_RESP,
    ST_DRAIN
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   aw_done;
  logic   w_done;
  logic   pend_rd;
  logic   misaligned;
  logic   aw_ok;
  logic   w_ok;

  always_comb begin
    case (lsu_op_m[1:0])
      cpu_pkg::OP_SZ_H: misaligned = addr_lo[0];
      cpu_pkg::OP_SZ_W: misaligned = |addr_lo[1:0];
      default:          misaligned = 1'b0;
    endcase
  end

  // handshake already done or happening now
  assign aw_ok = aw_done || awready;
  assign w_ok  = w_done || wready;

  assign arvalid = (state_q == ST_RD_ADDR);
  assign awvalid = (state_q == ST_WR) && !aw_done;
  assign wvalid  = (state_q == ST_WR) && !w_done;
  assign rready  = (state_q == ST_RD_DATA) || ((state_q == ST_DRAIN) && pend_rd);
  assign bready  = (state_q == ST_WR_RESP) || ((state_q == ST_DRAIN) && !pend_rd);

  assign lsu.busy = (state_q != ST_IDLE) && (state_q != ST_DRAIN);
  assign stop     = lsu.done;

  always_comb begin
    state_d   = state_q;
    lsu.done  = 1'b0;
    lsu.fault = 1'b0;
    start     = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (lsu_m) begin
          if (misaligned) begin
            state_d = ST_MISAL;
          end else if (lsu_op_m[cpu_pkg::OP_STORE_BIT]) begin
            state_d = ST_WR;
          end else begin
            state_d = ST_RD_ADDR;
          end
        end
      end
      ST_MISAL: begin
        lsu.done  = 1'b1;
        lsu.fault = 1'b1;
        state_d   = ST_IDLE;
      end
      ST_RD_ADDR: begin
        if (arready) begin
          start   = 1'b1;
          state_d = ST_RD_DATA;
        end
      end
      ST_RD_DATA: begin
        if (rvalid) begin
          lsu.done  = 1'b1;
          lsu.fault = (rresp != axi_pkg::OKAY);
          state_d   = ST_IDLE;
        end else if (expired) begin
          lsu.done  = 1'b1;
          lsu.fault = 1'b1;
          state_d   = ST_DRAIN;
        end
      end
      ST_WR: begin
        if (aw_ok && w_ok) begin
          start   = 1'b1;
          state_d = ST_WR_RESP;
        end
      end
      ST_WR_RESP: begin
        if (bvalid) begin
          lsu.done  = 1'b1;
          lsu.fault = (bresp != axi_pkg::OKAY);
          state_d   = ST_IDLE;
        end else if (expired) begin
          lsu.done  = 1'b1;
          lsu.fault = 1'b1;
          state_d   = ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        // late response is accepted and dropped
        if (pend_rd ? rvalid : bvalid) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // idle and drain stall only a waiting lsu op, busy states until done
  always_comb begin
    case (state_q)
      ST_IDLE, ST_DRAIN: mem_stall = lsu_m;
      default:           mem_stall = !lsu.done;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
      pend_rd <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_IDLE) begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end else if (state_q == ST_WR) begin
        if (awready) begin
          aw_done <= 1'b1;
        end
        if (wready) begin
          w_done <= 1'b1;
        end
      end
      // remember which channel a drain has to wait on
      if (state_q == ST_RD_DATA) begin
        pend_rd <= 1'b1;
      end else if (state_q == ST_WR_RESP) begin
        pend_rd <= 1'b0;
      end
    end
  end

endmodule

// ==== lsu_timer.sv ====
/*
 * lsu watchdog
 * counts cycles spent waiting for an AXI response, saturating at the limit
 */
`timescale 1ns/1ps

module lsu_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic stop,
  output logic expired
);

  logic [axi_pkg::TIMER_W-1:0] cnt;
  logic                        running;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt     <= '0;
      running <= 1'b0;
    end else if (start) begin
      cnt     <= '0;
      running <= 1'b1;
    end else if (stop) begin
      running <= 1'b0;
    end else if (running && (cnt != axi_pkg::TIMEOUT_MAX)) begin
      cnt <= cnt + 1'b1;
    end
  end

  assign expired = (cnt == axi_pkg::TIMEOUT_MAX);

endmodule

// ==== store_align.sv ====
/*
 * store alignment
 * replicates store data across byte lanes and builds the write strobe
 */
`timescale 1ns/1ps

module store_align (
  input  logic [axi_pkg::ADDR_W-1:0] addr,
  input  cpu_pkg::lsu_op_e           op,
  input  logic [cpu_pkg::XLEN-1:0]   store_data,
  output axi_pkg::beat_u             wdata,
  output logic [axi_pkg::STRB_W-1:0] wstrb,
  output axi_pkg::size_e             size
);

  logic [axi_pkg::STRB_W-1:0] strb_base;
  logic [2:0]                 lane_off;

  always_comb begin
    case (op[1:0])
      cpu_pkg::OP_SZ_B: begin
        wdata.bytes = {axi_pkg::STRB_W{store_data[7:0]}};
        strb_base   = 8'h01;
        lane_off    = addr[2:0];
        size        = axi_pkg::SIZE_1B;
      end
      cpu_pkg::OP_SZ_H: begin
        wdata.halves = {(axi_pkg::DATA_W / 16){store_data[15:0]}};
        strb_base    = 8'h03;
        lane_off     = {addr[2:1], 1'b0};
        size         = axi_pkg::SIZE_2B;
      end
      default: begin
        wdata.words = {(axi_pkg::DATA_W / 32){store_data}};
        strb_base   = 8'h0f;
        lane_off    = {addr[2], 2'b00};
        size        = axi_pkg::SIZE_4B;
      end
    endcase
    wstrb = strb_base << lane_off;
  end

endmodule

// ==== load_align.sv ====
/*
 * load alignment
 * picks the addressed lane of a read beat and sign or zero extends it
 */
`timescale 1ns/1ps

module load_align (
  input  logic [2:0]       addr_lo,
  input  cpu_pkg::lsu_op_e op,
  input  axi_pkg::beat_u   rdata,
  lsu_if.align             lsu
);

  logic [7:0]  byte_v;
  logic [15:0] half_v;
  logic [31:0] word_v;
  logic        ext_b;
  logic        ext_h;

  assign byte_v = rdata.bytes[addr_lo];
  assign half_v = rdata.halves[addr_lo[2:1]];
  assign word_v = rdata.words[addr_lo[2]];

  // fill bit is zero for LBU and LHU
  assign ext_b = !op[cpu_pkg::OP_UNSIGNED_BIT] && byte_v[7];
  assign ext_h = !op[cpu_pkg::OP_UNSIGNED_BIT] && half_v[15];

  always_comb begin
    case (op[1:0])
      cpu_pkg::OP_SZ_B: lsu.load_value = {{(cpu_pkg::XLEN - 8){ext_b}}, byte_v};
      cpu_pkg::OP_SZ_H: lsu.load_value = {{(cpu_pkg::XLEN - 16){ext_h}}, half_v};
      default:          lsu.load_value = word_v;
    endcase
  end

endmodule

// ==== mem_wb_reg.sv ====
/*
 * memory to writeback register
 * holds the writeback triple from the ALU result or the load value
 */
`timescale 1ns/1ps

module mem_wb_reg (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          lsu_m,
  input  logic                          rd_en_m,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr_m,
  input  logic [cpu_pkg::XLEN-1:0]      alu_res_m,
  lsu_if.wb                             lsu,
  output logic                          rd_en_wb,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr_wb,
  output logic [cpu_pkg::XLEN-1:0]      rd_data_wb,
  output logic                          mem_fault_wb
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_en_wb     <= 1'b0;
      rd_addr_wb   <= '0;
      rd_data_wb   <= '0;
      mem_fault_wb <= 1'b0;
    end else begin
      rd_addr_wb <= rd_addr_m;
      if (lsu.done) begin
        // faulted access never writes the register file
        rd_en_wb     <= rd_en_m && !lsu.fault;
        rd_data_wb   <= lsu.load_value;
        mem_fault_wb <= lsu.fault;
      end else if (lsu.busy || lsu_m) begin
        rd_en_wb     <= 1'b0;
        mem_fault_wb <= 1'b0;
      end else begin
        rd_en_wb     <= rd_en_m;
        rd_data_wb   <= alu_res_m;
        mem_fault_wb <= 1'b0;
      end
    end
  end

endmodule

// ==== mem_stage.sv ====
/*
 * RV32 memory stage
 * single-beat loads and stores over a 64-bit AXI master with stall and fault
 */
`timescale 1ns/1ps

module mem_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  // pipeline side
  input  logic                           lsu_m,
  input  cpu_pkg::lsu_op_e               lsu_op_m,
  input  logic [cpu_pkg::XLEN-1:0]       alu_res_m,
  input  logic [cpu_pkg::XLEN-1:0]       store_data_m,
  input  logic                           rd_en_m,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr_m,
  output logic                           rd_en_wb,
  output logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr_wb,
  output logic [cpu_pkg::XLEN-1:0]       rd_data_wb,
  output logic                           mem_fault_wb,
  output logic                           mem_stall,
  // read address and data
  output logic [axi_pkg::ADDR_W-1:0]     axi_araddr,
  output axi_pkg::size_e                 axi_arsize,
  output logic                           axi_arvalid,
  input  logic                           axi_arready,
  input  logic [axi_pkg::DATA_W-1:0]     axi_rdata,
  input  axi_pkg::resp_e                 axi_rresp,
  input  logic                           axi_rvalid,
  output logic                           axi_rready,
  // write address, data and response
  output logic [axi_pkg::ADDR_W-1:0]     axi_awaddr,
  output axi_pkg::size_e                 axi_awsize,
  output logic                           axi_awvalid,
  input  logic                           axi_awready,
  output logic [axi_pkg::DATA_W-1:0]     axi_wdata,
  output logic [axi_pkg::STRB_W-1:0]     axi_wstrb,
  output logic                           axi_wvalid,
  input  logic                           axi_wready,
  input  axi_pkg::resp_e                 axi_bresp,
  input  logic                           axi_bvalid,
  output logic                           axi_bready
);

  lsu_if          lsu_bus ();
  axi_pkg::size_e size;
  logic           tmr_start;
  logic           tmr_stop;
  logic           tmr_expired;

  // address comes straight from the execute result
  assign axi_araddr = alu_res_m;
  assign axi_awaddr = alu_res_m;
  assign axi_arsize = size;
  assign axi_awsize = size;

  lsu_fsm lsu_fsm_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .lsu_m     (lsu_m),
    .lsu_op_m  (lsu_op_m),
    .addr_lo   (alu_res_m[2:0]),
    .arvalid   (axi_arvalid),
    .arready   (axi_arready),
    .rvalid    (axi_rvalid),
    .rresp     (axi_rresp),
    .rready    (axi_rready),
    .awvalid   (axi_awvalid),
    .awready   (axi_awready),
    .wvalid    (axi_wvalid),
    .wready    (axi_wready),
    .bvalid    (axi_bvalid),
    .bresp     (axi_bresp),
    .bready    (axi_bready),
    .start     (tmr_start),
    .stop      (tmr_stop),
    .expired   (tmr_expired),
    .mem_stall (mem_stall),
    .lsu       (lsu_bus.fsm)
  );

  lsu_timer lsu_timer_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (tmr_start),
    .stop    (tmr_stop),
    .expired (tmr_expired)
  );

  store_align store_align_i (
    .addr       (alu_res_m),
    .op         (lsu_op_m),
    .store_data (store_data_m),
    .wdata      (axi_wdata),
    .wstrb      (axi_wstrb),
    .size       (size)
  );

  load_align load_align_i (
    .addr_lo (alu_res_m[2:0]),
    .op      (lsu_op_m),
    .rdata   (axi_rdata),
    .lsu     (lsu_bus.align)
  );

  mem_wb_reg mem_wb_reg_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_m        (lsu_m),
    .rd_en_m      (rd_en_m),
    .rd_addr_m    (rd_addr_m),
    .alu_res_m    (alu_res_m),
    .lsu          (lsu_bus.wb),
    .rd_en_wb     (rd_en_wb),
    .rd_addr_wb   (rd_addr_wb),
    .rd_data_wb   (rd_data_wb),
    .mem_fault_wb (mem_fault_wb)
  );

endmodule

// ==== tb_mem_stage.sv ====
/*
 * memory stage testbench
 * replays mem_stim.txt against an AXI memory model and checks writeback
 */
`timescale 1ns/1ps

module tb_mem_stage;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int MEM_BYTES   = 256;

  logic                           clk;
  logic                           rst_n;
  logic                           lsu_m;
  cpu_pkg::lsu_op_e               lsu_op_m;
  logic [cpu_pkg::XLEN-1:0]       alu_res_m;
  logic [cpu_pkg::XLEN-1:0]       store_data_m;
  logic                           rd_en_m;
  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr_m;
  logic                           rd_en_wb;
  logic [cpu_pkg::REG_ADDR_W-1:0] rd_addr_wb;
  logic [cpu_pkg::XLEN-1:0]       rd_data_wb;
  logic                           mem_fault_wb;
  logic                           mem_stall;
  logic [axi_pkg::ADDR_W-1:0]     axi_araddr;
  axi_pkg::size_e                 axi_arsize;
  logic                           axi_arvalid;
  logic                           axi_arready;
  logic [axi_pkg::DATA_W-1:0]     axi_rdata;
  axi_pkg::resp_e                 axi_rresp;
  logic                           axi_rvalid;
  logic                           axi_rready;
  logic [axi_pkg::ADDR_W-1:0]     axi_awaddr;
  axi_pkg::size_e                 axi_awsize;
  logic                           axi_awvalid;
  logic                           axi_awready;
  logic [axi_pkg::DATA_W-1:0]     axi_wdata;
  logic [axi_pkg::STRB_W-1:0]     axi_wstrb;
  logic                           axi_wvalid;
  logic                           axi_wready;
  axi_pkg::resp_e                 axi_bresp;
  logic                           axi_bvalid;
  logic                           axi_bready;

  logic [7:0] mem [0:MEM_BYTES-1];

  // one entry per stimulus line
  logic                           ln_lsu[$];
  logic [3:0]                     ln_op[$];
  logic [axi_pkg::ADDR_W-1:0]     ln_addr[$];
  logic [cpu_pkg::XLEN-1:0]       ln_sdata[$];
  logic [cpu_pkg::XLEN-1:0]       ln_alu[$];
  logic                           ln_rd_en[$];
  logic [cpu_pkg::REG_ADDR_W-1:0] ln_rd_addr[$];
  int                             ln_delay[$];
  logic [1:0]                     ln_resp[$];
  logic [cpu_pkg::XLEN-1:0]       ln_exp_data[$];
  logic                           ln_exp_fault[$];

  int                         line_idx;
  int                         resp_delay;
  axi_pkg::resp_e             resp_code;
  logic                       quiet_bus;
  logic                       no_stall;
  logic                       loaded;
  logic [axi_pkg::STRB_W-1:0] got_strb;
  int                         wr_count;
  // address and size of the latest AR or AW request
  axi_pkg::size_e             got_size;
  logic [axi_pkg::ADDR_W-1:0] got_addr;
  int                         req_count;

  mem_stage mem_stage_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_m        (lsu_m),
    .lsu_op_m     (lsu_op_m),
    .alu_res_m    (alu_res_m),
    .store_data_m (store_data_m),
    .rd_en_m      (rd_en_m),
    .rd_addr_m    (rd_addr_m),
    .rd_en_wb     (rd_en_wb),
    .rd_addr_wb   (rd_addr_wb),
    .rd_data_wb   (rd_data_wb),
    .mem_fault_wb (mem_fault_wb),
    .mem_stall    (mem_stall),
    .axi_araddr   (axi_araddr),
    .axi_arsize   (axi_arsize),
    .axi_arvalid  (axi_arvalid),
    .axi_arready  (axi_arready),
    .axi_rdata    (axi_rdata),
    .axi_rresp    (axi_rresp),
    .axi_rvalid   (axi_rvalid),
    .axi_rready   (axi_rready),
    .axi_awaddr   (axi_awaddr),
    .axi_awsize   (axi_awsize),
    .axi_awvalid  (axi_awvalid),
    .axi_awready  (axi_awready),
    .axi_wdata    (axi_wdata),
    .axi_wstrb    (axi_wstrb),
    .axi_wvalid   (axi_wvalid),
    .axi_wready   (axi_wready),
    .axi_bresp    (axi_bresp),
    .axi_bvalid   (axi_bvalid),
    .axi_bready   (axi_bready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic is_misaligned(input logic [3:0] op,
                                         input logic [axi_pkg::ADDR_W-1:0] addr);
    int unsigned nbytes;
    nbytes = 1 << op[1:0];
    return (addr % nbytes) != 0;
  endfunction

  // one strobe bit per addressed byte, none when the access never reaches the bus
  function automatic logic [axi_pkg::STRB_W-1:0] expected_strobe(
      input logic [3:0] op, input logic [axi_pkg::ADDR_W-1:0] addr);
    int unsigned nbytes;
    nbytes = 1 << op[1:0];
    if (is_misaligned(op, addr)) begin
      return '0;
    end
    return axi_pkg::STRB_W'(((1 << nbytes) - 1) << addr[2:0]);
  endfunction

  // size code from the number of bytes moved
  function automatic axi_pkg::size_e expected_size(input logic [3:0] op);
    int unsigned nbytes;
    nbytes = 1 << op[1:0];
    case (nbytes)
      1:       return axi_pkg::SIZE_1B;
      2:       return axi_pkg::SIZE_2B;
      default: return axi_pkg::SIZE_4B;
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic report_fail(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_data(input logic [cpu_pkg::XLEN-1:0] got,
                            input logic [cpu_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("line %0d rd_data_wb %h, expected %h", line_idx, got, exp));
    end
  endtask

  task automatic check_fault(input logic got, input logic exp);
    if (got !== exp) begin
      report_fail($sformatf("line %0d mem_fault_wb %b, expected %b", line_idx, got, exp));
    end
  endtask

  task automatic check_rd_en(input logic got, input logic exp);
    if (got !== exp) begin
      report_fail($sformatf("line %0d rd_en_wb %b, expected %b", line_idx, got, exp));
    end
  endtask

  task automatic check_rd_addr(input logic [cpu_pkg::REG_ADDR_W-1:0] got,
                               input logic [cpu_pkg::REG_ADDR_W-1:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("line %0d rd_addr_wb %h, expected %h", line_idx, got, exp));
    end
  endtask

  task automatic check_strb(input logic [axi_pkg::STRB_W-1:0] got,
                            input logic [axi_pkg::STRB_W-1:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("line %0d write strobe %h, expected %h", line_idx, got, exp));
    end
  endtask

  task automatic check_bus_addr(input logic [axi_pkg::ADDR_W-1:0] got,
                                input logic [axi_pkg::ADDR_W-1:0] exp);
    if (got !== exp) begin
      report_fail($sformatf("line %0d AXI address %h, expected %h", line_idx, got, exp));
    end
  endtask

  task automatic check_size(input axi_pkg::size_e got, input axi_pkg::size_e exp);
    if (got !== exp) begin
      report_fail($sformatf("line %0d AXI size %0d, expected %0d", line_idx, got, exp));
    end
  endtask

  task automatic load_stimulus();
    int                             fd;
    int                             n;
    string                          text;
    logic                           f_lsu;
    logic [3:0]                     f_op;
    logic [axi_pkg::ADDR_W-1:0]     f_addr;
    logic [cpu_pkg::XLEN-1:0]       f_sdata;
    logic [cpu_pkg::XLEN-1:0]       f_alu;
    logic                           f_rd_en;
    logic [cpu_pkg::REG_ADDR_W-1:0] f_rd_addr;
    int                             f_delay;
    logic [1:0]                     f_resp;
    logic [cpu_pkg::XLEN-1:0]       f_exp;
    logic                           f_fault;
    fd = $fopen("mem_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file mem_stim.txt");
      $display("test failed");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      text = "";
      n = $fgets(text, fd);
      // comment and blank lines do not parse into all eleven fields
      n = $sscanf(text, "%h %h %h %h %h %h %h %d %h %h %h", f_lsu, f_op, f_addr,
                  f_sdata, f_alu, f_rd_en, f_rd_addr, f_delay, f_resp, f_exp, f_fault);
      if (n == 11) begin
        ln_lsu.push_back(f_lsu);
        ln_op.push_back(f_op);
        ln_addr.push_back(f_addr);
        ln_sdata.push_back(f_sdata);
        ln_alu.push_back(f_alu);
        ln_rd_en.push_back(f_rd_en);
        ln_rd_addr.push_back(f_rd_addr);
        ln_delay.push_back(f_delay);
        ln_resp.push_back(f_resp);
        ln_exp_data.push_back(f_exp);
        ln_exp_fault.push_back(f_fault);
      end
    end
    $fclose(fd);
  endtask

  // AR then R channel, response held back by the line's delay
  initial begin : read_responder
    logic [31:0]    rng;
    logic [7:0]     base;
    int             ready_wait;
    int             resp_wait;
    axi_pkg::resp_e code;
    axi_pkg::beat_u rd_beat;
    rng         = 32'd4;
    axi_arready = 1'b0;
    axi_rvalid  = 1'b0;
    axi_rdata   = '0;
    axi_rresp   = axi_pkg::OKAY;
    forever begin
      @(negedge clk);
      if (axi_arvalid) begin
        got_size   = axi_arsize;
        got_addr   = axi_araddr;
        req_count++;
        base       = {axi_araddr[7:3], 3'b000};
        resp_wait  = resp_delay;
        code       = resp_code;
        rng        = xorshift32(rng);
        ready_wait = int'(rng[1:0]);
        repeat (ready_wait) next_cycle();
        next_cycle();
        axi_arready = 1'b1;
        @(negedge clk);
        next_cycle();
        axi_arready = 1'b0;
        repeat (resp_wait) next_cycle();
        for (int i = 0; i < axi_pkg::STRB_W; i++) begin
          rd_beat.bytes[i] = mem[base + i];
        end
        axi_rdata  = rd_beat;
        axi_rresp  = code;
        axi_rvalid = 1'b1;
        @(negedge clk);
        while (!axi_rready) @(negedge clk);
        next_cycle();
        axi_rvalid = 1'b0;
      end
    end
  end

  // AW and W accepted independently, then one B response
  initial begin : write_responder
    logic [31:0]    rng;
    logic [7:0]     base;
    int             aw_wait;
    int             w_wait;
    int             resp_wait;
    logic           aw_seen;
    logic           w_seen;
    axi_pkg::resp_e code;
    axi_pkg::beat_u wr_beat;
    rng         = 32'd4;
    wr_count    = 0;
    got_strb    = '0;
    axi_awready = 1'b0;
    axi_wready  = 1'b0;
    axi_bvalid  = 1'b0;
    axi_bresp   = axi_pkg::OKAY;
    // fill byte depends on every address bit
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem[a] = 8'(a) ^ 8'ha5;
    end
    forever begin
      @(negedge clk);
      if (axi_awvalid || axi_wvalid) begin
        got_size  = axi_awsize;
        got_addr  = axi_awaddr;
        req_count++;
        base      = {axi_awaddr[7:3], 3'b000};
        resp_wait = resp_delay;
        code      = resp_code;
        rng       = xorshift32(rng);
        aw_wait   = int'(rng[1:0]);
        rng       = xorshift32(rng);
        w_wait    = int'(rng[1:0]);
        aw_seen   = 1'b0;
        w_seen    = 1'b0;
        while (!(aw_seen && w_seen)) begin
          next_cycle();
          axi_awready = !aw_seen && (aw_wait == 0);
          axi_wready  = !w_seen && (w_wait == 0);
          if (aw_wait > 0) begin
            aw_wait--;
          end
          if (w_wait > 0) begin
            w_wait--;
          end
          @(negedge clk);
          if (axi_awvalid && axi_awready) begin
            aw_seen = 1'b1;
          end
          if (axi_wvalid && axi_wready) begin
            w_seen   = 1'b1;
            wr_beat  = axi_wdata;
            got_strb = axi_wstrb;
            wr_count++;
            for (int i = 0; i < axi_pkg::STRB_W; i++) begin
              if (axi_wstrb[i]) begin
                mem[base + i] = wr_beat.bytes[i];
              end
            end
          end
        end
        next_cycle();
        axi_awready = 1'b0;
        axi_wready  = 1'b0;
        repeat (resp_wait) next_cycle();
        axi_bresp  = code;
        axi_bvalid = 1'b1;
        @(negedge clk);
        while (!axi_bready) @(negedge clk);
        next_cycle();
        axi_bvalid = 1'b0;
      end
    end
  end

  // mid-cycle look at signals that must stay quiet for the current line
  initial begin : bus_monitor
    forever begin
      @(negedge clk);
      if (quiet_bus && (axi_arvalid || axi_awvalid || axi_wvalid)) begin
        report_fail($sformatf("line %0d AXI valid raised for a misaligned access",
                              line_idx));
      end
      if (no_stall && mem_stall) begin
        report_fail($sformatf("line %0d mem_stall rose for a non-memory line", line_idx));
      end
    end
  end

  initial begin : watchdog
    wait (loaded === 1'b1);
    repeat (ln_lsu.size() * 40 + 50) @(posedge clk);
    $display("timeout, the memory stage did not finish the stimulus in time");
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    int                         wr_start;
    int                         req_start;
    logic                       exp_en;
    logic [axi_pkg::STRB_W-1:0] seen_strb;
    rst_n        = 1'b0;
    lsu_m        = 1'b0;
    lsu_op_m     = cpu_pkg::LB;
    alu_res_m    = '0;
    store_data_m = '0;
    rd_en_m      = 1'b0;
    rd_addr_m    = '0;
    resp_delay   = 0;
    resp_code    = axi_pkg::OKAY;
    quiet_bus    = 1'b0;
    no_stall     = 1'b0;
    loaded       = 1'b0;
    got_size     = axi_pkg::SIZE_1B;
    got_addr     = '0;
    req_count    = 0;
    line_idx     = -1;
    load_stimulus();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    check_data(rd_data_wb, '0);
    check_rd_addr(rd_addr_wb, '0);
    check_fault(mem_fault_wb, 1'b0);
    check_rd_en(rd_en_wb, 1'b0);
    for (int k = 0; k < ln_lsu.size(); k++) begin
      line_idx     = k;
      lsu_m        = ln_lsu[k];
      lsu_op_m     = cpu_pkg::lsu_op_e'(ln_op[k]);
      alu_res_m    = ln_lsu[k] ? ln_addr[k] : ln_alu[k];
      store_data_m = ln_sdata[k];
      rd_en_m      = ln_rd_en[k];
      rd_addr_m    = ln_rd_addr[k];
      resp_delay   = ln_delay[k];
      resp_code    = axi_pkg::resp_e'(ln_resp[k]);
      quiet_bus    = ln_lsu[k] && is_misaligned(ln_op[k], ln_addr[k]);
      no_stall     = !ln_lsu[k];
      wr_start     = wr_count;
      req_start    = req_count;
      // the access ends in the cycle where the stall is low
      @(negedge clk);
      while (mem_stall) @(negedge clk);
      @(posedge clk);
      #DRIVE_DELAY;
      exp_en = ln_rd_en[k] && !ln_exp_fault[k];
      check_fault(mem_fault_wb, ln_exp_fault[k]);
      check_rd_en(rd_en_wb, exp_en);
      if (exp_en) begin
        check_data(rd_data_wb, ln_exp_data[k]);
        check_rd_addr(rd_addr_wb, ln_rd_addr[k]);
      end
      if (ln_lsu[k] && !is_misaligned(ln_op[k], ln_addr[k])) begin
        if (req_count == req_start) begin
          report_fail($sformatf("line %0d issued no AXI request", line_idx));
        end
        check_bus_addr(got_addr, ln_addr[k]);
        check_size(got_size, expected_size(ln_op[k]));
      end
      if (ln_lsu[k] && ln_op[k][cpu_pkg::OP_STORE_BIT]) begin
        seen_strb = (wr_count != wr_start) ? got_strb : '0;
        check_strb(seen_strb, expected_strobe(ln_op[k], ln_addr[k]));
      end
    end
    lsu_m     = 1'b0;
    quiet_bus = 1'b0;
    no_stall  = 1'b0;
    repeat (2) @(posedge clk);
    $display("test passed");
    $finish;
  end

endmodule

// ==== mem_stim.txt ====
// lsu op addr store_data alu_res rd_en rd_addr delay resp exp_data exp_fault
// all fields hex except delay in decimal cycles, op uses the lsu_op_e encoding
0 0 00000000 00000000 12345678 1 01 0 0 12345678 0
1 a 00000040 8badf00d 00000000 0 00 1 0 00000000 0
1 2 00000040 00000000 00000000 1 03 2 0 8badf00d 0
1 8 00000045 000000e7 00000000 0 00 0 0 00000000 0
1 0 00000045 00000000 00000000 1 04 3 0 ffffffe7 0
1 4 00000045 00000000 00000000 1 05 0 0 000000e7 0
1 9 0000004a 00009c31 00000000 0 00 2 0 00000000 0
1 1 0000004a 00000000 00000000 1 06 1 0 ffff9c31 0
1 5 0000004a 00000000 00000000 1 07 4 0 00009c31 0
0 0 00000000 00000000 deadbeef 1 08 0 0 deadbeef 0
1 0 00000013 00000000 00000000 1 09 0 0 ffffffb6 0
1 4 00000022 00000000 00000000 1 0a 5 0 00000087 0
1 1 00000026 00000000 00000000 1 0b 1 0 ffff8283 0
1 5 00000036 00000000 00000000 1 0c 0 0 00009293 0
1 2 0000001c 00000000 00000000 1 0d 3 0 babbb8b9 0
1 a 00000054 0badcafe 00000000 0 00 2 0 00000000 0
1 2 00000054 00000000 00000000 1 0e 0 0 0badcafe 0
1 2 00000060 00000000 00000000 1 0f 1 2 00000000 1
1 2 00000068 00000000 00000000 1 10 20 0 00000000 1
1 2 00000040 00000000 00000000 1 11 0 0 8badf00d 0
1 1 00000031 00000000 00000000 1 12 0 0 00000000 1
1 a 00000042 11223344 00000000 0 00 0 0 00000000 1
1 8 00000070 000000aa 00000000 0 00 1 2 00000000 1
0 0 00000000 00000000 00c0ffee 1 13 0 0 00c0ffee 0

// ==== src.f ====
cpu_pkg.sv
axi_pkg.sv
lsu_if.sv
lsu_fsm.sv
lsu_timer.sv
store_align.sv
load_align.sv
mem_wb_reg.sv
mem_stage.sv
tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - files:
      - cpu_pkg.sv
      - axi_pkg.sv
      - lsu_if.sv
      - lsu_fsm.sv
      - lsu_timer.sv
      - store_align.sv
      - load_align.sv
      - mem_wb_reg.sv
      - mem_stage.sv
  - target: test
    files:
      - tb_mem_stage.sv
